//--- tb.f
isaPkg.sv
ctrlPkg.sv
instrDecoder.sv
stepSequencer.sv
controlEncoder.sv
controlUnit.sv
tbControlUnit.sv

//--- run.sh
#!/bin/sh
# Compile and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

logFile=sim.log
simBinary=obj_dir/simControlUnit

verilator --binary --timing --assert -f tb.f --top-module tbControlUnit -o simControlUnit
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"$simBinary" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "^Everything OK$" "$logFile"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

//--- tbControlUnit.sv
`timescale 1ns/100ps
`default_nettype none

module tbControlUnit;
    import isaPkg::*;
    import ctrlPkg::*;

    // Timing class of one instruction as seen from the ports
    typedef enum {catStart, catArith, catJump, catJal, catTrap, catIllegal} categoryType;

    localparam int clockPeriod = 40;
    localparam int directedCount = 17;
    localparam int randomCount = 40;
    localparam int instrCount = directedCount + randomCount;
    localparam int watchdogCycles = instrCount * 12 + 20;

    logic clock = 1'b0;
    logic reset;
    opcodeType opcode;
    functType funct;
    logic overflow;
    logic memWrite;
    logic irWrite;
    logic regWrite;
    logic pcWrite;
    logic regAWrite;
    logic regBWrite;
    logic aluOutWrite;
    logic epcWrite;
    logic exceptionSelect;
    logic resetOut;
    aluOpType aluOp;
    aluSrcAType aluSrcA;
    aluSrcBType aluSrcB;
    pcSourceType pcSource;
    iorDType iorD;
    regDstType regDst;
    dataSourceType dataSource;

    integer seed;
    logic [31:0] randomBits;
    int index;
    int errorCount = 0;
    int checkCount = 0;
    logic released = 1'b0;
    int cycleCount = 0;
    int nextCount;
    logic [3:0] writes;
    categoryType activeCat = catStart;
    categoryType pendingCat = catStart;
    regDstType activeDst = dstRd;
    regDstType pendingDst;
    pcSourceType activePc = pcFromAlu;
    pcSourceType pendingPc;
    aluOpType activeOp = aluAdd;
    aluOpType pendingOp;
    aluSrcBType activeSrcB = srcBRegB;
    aluSrcBType pendingSrcB;

    controlUnit uut (.*);

    initial begin
        forever #(clockPeriod / 2) clock = ~clock;
    end

    task automatic checkBit(input string name, input logic got, input logic expected);
        checkCount++;
        assert (got === expected) else begin
            errorCount++;
            $display("Mismatch %s: got %h, expected %h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic checkField(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        checkCount++;
        assert (got === expected) else begin
            errorCount++;
            $display("Mismatch %s: got %h, expected %h at %0t", name, got, expected, $time);
        end
    endtask

    // Cycles from one irWrite to the next
    function automatic int expectedLength(categoryType cat);
        case (cat)
            catStart: return 3;
            catArith: return 8;
            catJump: return 7;
            catJal: return 9;
            catTrap: return 11;
            default: return 10;
        endcase
    endfunction

    // Bits are regWrite, pcWrite, epcWrite, exceptionSelect with cycle 0 at irWrite
    function automatic logic [3:0] expectedWrites(categoryType cat, int cyc);
        logic [3:0] bits;
        bits = {1'b0, (cyc == 0) && (cat != catStart), 2'b00};
        case (cat)
            catArith: begin
                bits[3] = (cyc == 5);
            end
            catJump: begin
                bits[2] = bits[2] | (cyc == 4);
            end
            catJal: begin
                bits[3] = (cyc == 5);
                bits[2] = bits[2] | (cyc == 6);
            end
            catTrap: begin
                bits[1] = (cyc == 5);
                bits[2] = bits[2] | (cyc == 8);
                bits[0] = (cyc == 8);
            end
            catIllegal: begin
                bits[1] = (cyc == 4);
                bits[2] = bits[2] | (cyc == 7);
                bits[0] = (cyc == 7);
            end
            default: begin
            end
        endcase
        return bits;
    endfunction

    // Branch target in cycle 2, then the compute step of arithmetic and jal
    function automatic logic expectedAluOutWrite(categoryType cat, int cyc);
        if (cat == catStart) begin
            return 1'b0;
        end
        return (cyc == 2)
            || ((cyc == 4) && (cat == catArith || cat == catTrap || cat == catJal));
    endfunction

    task automatic checkCycle();
        writes = expectedWrites(activeCat, cycleCount);
        checkBit("resetOut", resetOut, 1'b0);
        checkBit("regWrite", regWrite, writes[3]);
        checkBit("pcWrite", pcWrite, writes[2]);
        checkBit("epcWrite", epcWrite, writes[1]);
        checkBit("exceptionSelect", exceptionSelect, writes[0]);
        // Operand registers load right after the instruction
        checkBit("regAWrite", regAWrite, (cycleCount == 1) && (activeCat != catStart));
        checkBit("regBWrite", regBWrite, (cycleCount == 1) && (activeCat != catStart));
        checkBit("aluOutWrite", aluOutWrite, expectedAluOutWrite(activeCat, cycleCount));
        if (cycleCount == 0) begin
            // PC + 4 while the instruction loads
            checkField("aluOp", 32'(aluOp), 32'(aluAdd));
            checkField("aluSrcA", 32'(aluSrcA), 32'(srcAPc));
            checkField("aluSrcB", 32'(aluSrcB), 32'(srcBFour));
        end
        if ((activeCat == catArith || activeCat == catTrap) && cycleCount == 4) begin
            checkField("aluOp", 32'(aluOp), 32'(activeOp));
            checkField("aluSrcA", 32'(aluSrcA), 32'(srcARegA));
            checkField("aluSrcB", 32'(aluSrcB), 32'(activeSrcB));
        end
        if (activeCat == catArith && cycleCount == 5) begin
            checkField("regDst", 32'(regDst), 32'(activeDst));
        end
        if (activeCat == catJump && cycleCount == 4) begin
            checkField("pcSource", 32'(pcSource), 32'(activePc));
        end
        if (activeCat == catJal && cycleCount == 5) begin
            checkField("regDst", 32'(regDst), 32'(dstReturn));
        end
        if (activeCat == catJal && cycleCount == 6) begin
            checkField("pcSource", 32'(pcSource), 32'(pcFromJump));
        end
        // Vector select one cycle after the EPC save
        if (activeCat == catTrap && cycleCount == 6) begin
            checkField("iorD", 32'(iorD), 32'(addrOverflowVector));
        end
        if (activeCat == catIllegal && cycleCount == 5) begin
            checkField("iorD", 32'(iorD), 32'(addrIllegalVector));
        end
    endtask

    // Outputs are settled at the falling edge
    always @(negedge clock) begin
        checkBit("memWrite", memWrite, 1'b0);
        if (reset || !released) begin
            // Stack pointer write lasts through reset and one cycle more
            checkBit("resetOut", resetOut, 1'b1);
            checkBit("regWrite", regWrite, 1'b1);
            checkBit("pcWrite", pcWrite, 1'b0);
            checkBit("irWrite", irWrite, 1'b0);
            checkBit("regAWrite", regAWrite, 1'b0);
            checkBit("regBWrite", regBWrite, 1'b0);
            checkBit("aluOutWrite", aluOutWrite, 1'b0);
            checkBit("epcWrite", epcWrite, 1'b0);
            checkBit("exceptionSelect", exceptionSelect, 1'b0);
            checkField("dataSource", 32'(dataSource), 32'(dataStackTop));
            checkField("regDst", 32'(regDst), 32'(dstRt));
            if (!reset) begin
                released = 1'b1;
                cycleCount = 0;
                activeCat = catStart;
            end
        end else begin
            nextCount = cycleCount + 1;
            checkBit("irWrite", irWrite, nextCount == expectedLength(activeCat));
            if (irWrite) begin
                cycleCount = 0;
                activeCat = pendingCat;
                activeDst = pendingDst;
                activePc = pendingPc;
                activeOp = pendingOp;
                activeSrcB = pendingSrcB;
            end else begin
                cycleCount = nextCount;
            end
            checkCycle();
        end
    end

    // Poll just after each edge until the instruction register loads
    task automatic waitForFetch();
        do begin
            @(posedge clock);
            #2;
        end while (irWrite !== 1'b1);
    endtask

    // Indexes 0 to 9 are the kept kinds and 10 and 11 unsupported encodings
    task automatic applyInstruction(input int which, input logic ovf);
        opcode = opRType;
        funct = functAdd;
        overflow = ovf;
        pendingCat = catArith;
        pendingDst = dstRd;
        pendingPc = pcFromAlu;
        pendingOp = aluAdd;
        pendingSrcB = srcBRegB;
        case (which)
            0: begin
                pendingCat = ovf ? catTrap : catArith;
            end
            1: begin
                funct = functSub;
                pendingOp = aluSub;
                pendingCat = ovf ? catTrap : catArith;
            end
            2: begin
                funct = functAnd;
                pendingOp = aluAnd;
            end
            3: begin
                opcode = opAddi;
                pendingDst = dstRt;
                pendingSrcB = srcBImmediate;
                pendingCat = ovf ? catTrap : catArith;
            end
            4: begin
                opcode = opAddiu;
                pendingDst = dstRt;
                pendingSrcB = srcBImmediate;
            end
            5: begin
                opcode = opJ;
                pendingCat = catJump;
                pendingPc = pcFromJump;
            end
            6: begin
                opcode = opJal;
                pendingCat = catJal;
            end
            7: begin
                funct = functJr;
                pendingCat = catJump;
            end
            8: begin
                funct = functBreak;
                pendingCat = catJump;
            end
            9: begin
                funct = functRte;
                pendingCat = catJump;
                pendingPc = pcFromEpc;
            end
            10: begin
                // Load word
                opcode = opcodeType'(6'b100011);
                pendingCat = catIllegal;
            end
            default: begin
                // Shift left logical
                funct = functType'(6'b000000);
                pendingCat = catIllegal;
            end
        endcase
    endtask

    initial begin
        seed = 77860;
        reset = 1'b1;
        overflow = 1'b0;
        opcode = opRType;
        funct = functAdd;
        pendingDst = dstRd;
        pendingPc = pcFromAlu;
        pendingOp = aluAdd;
        pendingSrcB = srcBRegB;
        repeat (4) @(posedge clock);
        #2;
        reset = 1'b0;
        for (int n = 0; n < instrCount; n++) begin
            waitForFetch();
            if (n < 12) begin
                applyInstruction(n, 1'b0);
            end else if (n < directedCount) begin
                // Arithmetic kinds again with overflow high
                applyInstruction(n - 12, 1'b1);
            end else begin
                randomBits = $random(seed);
                index = randomBits % 12;
                randomBits = $random(seed);
                applyInstruction(index, randomBits[0]);
            end
        end
        waitForFetch();
        @(negedge clock);
        #1;
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(watchdogCycles * clockPeriod);
        $display("Timeout: the instruction sequence did not end within %0d cycles",
                 watchdogCycles);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- controlUnit.sv
`timescale 1ns/100ps
`default_nettype none

module controlUnit (
    input wire clock,
    input wire reset,
    input wire isaPkg::opcodeType opcode,
    input wire isaPkg::functType funct,
    input wire overflow,
    output logic memWrite,
    output logic irWrite,
    output logic regWrite,
    output logic pcWrite,
    output logic regAWrite,
    output logic regBWrite,
    output logic aluOutWrite,
    output logic epcWrite,
    output logic exceptionSelect,
    output logic resetOut,
    output ctrlPkg::aluOpType aluOp,
    output ctrlPkg::aluSrcAType aluSrcA,
    output ctrlPkg::aluSrcBType aluSrcB,
    output ctrlPkg::pcSourceType pcSource,
    output ctrlPkg::iorDType iorD,
    output ctrlPkg::regDstType regDst,
    output ctrlPkg::dataSourceType dataSource
);
    import isaPkg::*;
    import ctrlPkg::*;

    instrKind kind;
    instrKind activeKind;
    phaseType phase;
    logic [stepWidth-1:0] step;
    causeType cause;

    instrDecoder decoder (
        .opcode(opcode),
        .funct(funct),
        .kind(kind)
    );

    stepSequencer sequencer (
        .clock(clock),
        .reset(reset),
        .kind(kind),
        .overflow(overflow),
        .phase(phase),
        .step(step),
        .activeKind(activeKind),
        .cause(cause)
    );

    // Control levels follow the registered phase and step
    controlEncoder encoder (
        .phase(phase),
        .step(step),
        .activeKind(activeKind),
        .cause(cause),
        .memWrite(memWrite),
        .irWrite(irWrite),
        .regWrite(regWrite),
        .pcWrite(pcWrite),
        .regAWrite(regAWrite),
        .regBWrite(regBWrite),
        .aluOutWrite(aluOutWrite),
        .epcWrite(epcWrite),
        .exceptionSelect(exceptionSelect),
        .resetOut(resetOut),
        .aluOp(aluOp),
        .aluSrcA(aluSrcA),
        .aluSrcB(aluSrcB),
        .pcSource(pcSource),
        .iorD(iorD),
        .regDst(regDst),
        .dataSource(dataSource)
    );

endmodule

`default_nettype wire

//--- controlEncoder.sv
`timescale 1ns/100ps
`default_nettype none

module controlEncoder (
    input wire ctrlPkg::phaseType phase,
    input wire [ctrlPkg::stepWidth-1:0] step,
    input wire isaPkg::instrKind activeKind,
    input wire ctrlPkg::causeType cause,
    output logic memWrite,
    output logic irWrite,
    output logic regWrite,
    output logic pcWrite,
    output logic regAWrite,
    output logic regBWrite,
    output logic aluOutWrite,
    output logic epcWrite,
    output logic exceptionSelect,
    output logic resetOut,
    output ctrlPkg::aluOpType aluOp,
    output ctrlPkg::aluSrcAType aluSrcA,
    output ctrlPkg::aluSrcBType aluSrcB,
    output ctrlPkg::pcSourceType pcSource,
    output ctrlPkg::iorDType iorD,
    output ctrlPkg::regDstType regDst,
    output ctrlPkg::dataSourceType dataSource
);
    import isaPkg::*;
    import ctrlPkg::*;

    logic immOperand;
    aluOpType arithOp;
    iorDType vectorAddr;

    assign immOperand = (activeKind == kindAddi) || (activeKind == kindAddiu);
    assign vectorAddr = (cause == causeOverflow) ? addrOverflowVector : addrIllegalVector;

    always_comb begin
        case (activeKind)
            kindSub: arithOp = aluSub;
            kindAnd: arithOp = aluAnd;
            default: arithOp = aluAdd;
        endcase
    end

    always_comb begin
        memWrite = 1'b0;
        irWrite = 1'b0;
        regWrite = 1'b0;
        pcWrite = 1'b0;
        regAWrite = 1'b0;
        regBWrite = 1'b0;
        aluOutWrite = 1'b0;
        epcWrite = 1'b0;
        exceptionSelect = 1'b0;
        resetOut = 1'b0;
        aluOp = aluPass;
        aluSrcA = srcAPc;
        aluSrcB = srcBRegB;
        pcSource = pcFromAlu;
        iorD = addrPc;
        regDst = dstRt;
        dataSource = dataAluOut;
        case (phase)
            resetHold: begin
                // Initial stack pointer write
                resetOut = 1'b1;
                regWrite = 1'b1;
                regDst = dstRt;
                dataSource = dataStackTop;
            end
            fetchAddress, fetchWait, fetchLoad: begin
                // PC + 4 on the ALU through the whole fetch
                iorD = addrPc;
                aluSrcA = srcAPc;
                aluSrcB = srcBFour;
                aluOp = aluAdd;
                pcSource = pcFromAlu;
                if (phase == fetchLoad) begin
                    irWrite = 1'b1;
                    pcWrite = 1'b1;
                end
            end
            regRead: begin
                regAWrite = 1'b1;
                regBWrite = 1'b1;
            end
            branchCalc: begin
                // Branch target kept in ALUOut
                aluSrcA = srcAPc;
                aluSrcB = srcBOffsetShifted;
                aluOp = aluAdd;
                aluOutWrite = 1'b1;
            end
            execute: begin
                case (activeKind)
                    kindAdd, kindSub, kindAnd, kindAddi, kindAddiu: begin
                        if (step == stepWidth'(0)) begin
                            aluSrcA = srcARegA;
                            aluSrcB = immOperand ? srcBImmediate : srcBRegB;
                            aluOp = arithOp;
                            aluOutWrite = 1'b1;
                        end else begin
                            regDst = immOperand ? dstRt : dstRd;
                            dataSource = dataAluOut;
                            regWrite = 1'b1;
                        end
                    end
                    kindJ: begin
                        pcSource = pcFromJump;
                        pcWrite = 1'b1;
                    end
                    kindJr: begin
                        aluSrcA = srcARegA;
                        aluOp = aluPass;
                        pcSource = pcFromAlu;
                        pcWrite = 1'b1;
                    end
                    kindBreak: begin
                        // Back to the break itself
                        aluSrcA = srcAPc;
                        aluSrcB = srcBFour;
                        aluOp = aluSub;
                        pcSource = pcFromAlu;
                        pcWrite = 1'b1;
                    end
                    kindRte: begin
                        pcSource = pcFromEpc;
                        pcWrite = 1'b1;
                    end
                    kindJal: begin
                        if (step == stepWidth'(0)) begin
                            aluSrcA = srcAPc;
                            aluOp = aluPass;
                            aluOutWrite = 1'b1;
                        end else if (step == stepWidth'(1)) begin
                            regDst = dstReturn;
                            dataSource = dataAluOut;
                            regWrite = 1'b1;
                        end else begin
                            pcSource = pcFromJump;
                            pcWrite = 1'b1;
                        end
                    end
                    default: begin
                    end
                endcase
            end
            exception: begin
                if (step == stepWidth'(0)) begin
                    // EPC gets the address of the faulting instruction
                    aluSrcA = srcAPc;
                    aluSrcB = srcBFour;
                    aluOp = aluSub;
                    epcWrite = 1'b1;
                end else if (step == exceptionLastStep) begin
                    exceptionSelect = 1'b1;
                    pcWrite = 1'b1;
                end else begin
                    // Vector address held through the wait step
                    iorD = vectorAddr;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- stepSequencer.sv
`timescale 1ns/100ps
`default_nettype none

module stepSequencer (
    input wire clock,
    input wire reset,
    input wire isaPkg::instrKind kind,
    input wire overflow,
    output ctrlPkg::phaseType phase,
    output logic [ctrlPkg::stepWidth-1:0] step,
    output isaPkg::instrKind activeKind,
    output ctrlPkg::causeType cause
);
    import isaPkg::*;
    import ctrlPkg::*;

    // Final execute step of the latched kind
    logic [stepWidth-1:0] lastExecStep;
    logic trapsOverflow;
    logic overflowTrap;

    always_comb begin
        case (activeKind)
            kindAdd, kindSub, kindAnd, kindAddi, kindAddiu: begin
                // Compute then writeback
                lastExecStep = stepWidth'(1);
            end
            kindJal: begin
                // Link compute, link write, jump
                lastExecStep = stepWidth'(2);
            end
            default: begin
                lastExecStep = '0;
            end
        endcase
    end

    // Only signed arithmetic traps, and only after its compute step
    assign trapsOverflow = (activeKind == kindAdd) || (activeKind == kindSub)
                        || (activeKind == kindAddi);
    assign overflowTrap = trapsOverflow && overflow && (step == '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            phase <= resetHold;
            step <= '0;
            activeKind <= kindIllegal;
            cause <= causeIllegal;
        end else begin
            case (phase)
                resetHold: begin
                    phase <= fetchAddress;
                end
                fetchAddress: begin
                    phase <= fetchWait;
                end
                // One cycle for the memory to answer
                fetchWait: begin
                    phase <= fetchLoad;
                end
                fetchLoad: begin
                    phase <= regRead;
                end
                regRead: begin
                    phase <= branchCalc;
                end
                branchCalc: begin
                    phase <= decode;
                end
                decode: begin
                    activeKind <= kind;
                    step <= '0;
                    if (kind == kindIllegal) begin
                        cause <= causeIllegal;
                        phase <= exception;
                    end else begin
                        phase <= execute;
                    end
                end
                execute: begin
                    if (overflowTrap) begin
                        cause <= causeOverflow;
                        phase <= exception;
                        step <= '0;
                    end else if (step == lastExecStep) begin
                        phase <= fetchAddress;
                        step <= '0;
                    end else begin
                        step <= step + stepWidth'(1);
                    end
                end
                exception: begin
                    if (step == exceptionLastStep) begin
                        phase <= fetchAddress;
                        step <= '0;
                    end else begin
                        step <= step + stepWidth'(1);
                    end
                end
                default: begin
                    phase <= fetchAddress;
                    step <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- instrDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module instrDecoder (
    input wire isaPkg::opcodeType opcode,
    input wire isaPkg::functType funct,
    output isaPkg::instrKind kind
);
    import isaPkg::*;

    always_comb begin
        kind = kindIllegal;
        case (opcode)
            opRType: begin
                // R-type work is chosen by the funct field
                case (funct)
                    functAdd: begin
                        kind = kindAdd;
                    end
                    functSub: begin
                        kind = kindSub;
                    end
                    functAnd: begin
                        kind = kindAnd;
                    end
                    functJr: begin
                        kind = kindJr;
                    end
                    functBreak: begin
                        kind = kindBreak;
                    end
                    functRte: begin
                        kind = kindRte;
                    end
                    default: begin
                        kind = kindIllegal;
                    end
                endcase
            end
            opAddi: begin
                kind = kindAddi;
            end
            opAddiu: begin
                kind = kindAddiu;
            end
            opJ: begin
                kind = kindJ;
            end
            opJal: begin
                kind = kindJal;
            end
            // Shifts, branches, loads and stores land here too
            default: begin
                kind = kindIllegal;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- ctrlPkg.sv
`default_nettype none

package ctrlPkg;

    localparam int stepWidth = 3;

    // Exception entry runs save, vector address, wait and load
    localparam logic [stepWidth-1:0] exceptionLastStep = 3'd3;

    // Top level phases of one instruction
    typedef enum logic [3:0] {
        resetHold,
        fetchAddress,
        fetchWait,
        fetchLoad,
        regRead,
        branchCalc,
        decode,
        execute,
        exception
    } phaseType;

    typedef enum logic {
        causeOverflow,
        causeIllegal
    } causeType;

    typedef enum logic [2:0] {
        aluPass = 3'b000,
        aluAdd  = 3'b001,
        aluSub  = 3'b010,
        aluAnd  = 3'b011
    } aluOpType;

    typedef enum logic [1:0] {
        srcAPc   = 2'b01,
        srcARegA = 2'b10
    } aluSrcAType;

    typedef enum logic [1:0] {
        srcBImmediate     = 2'b00,
        srcBFour          = 2'b01,
        srcBRegB          = 2'b10,
        srcBOffsetShifted = 2'b11
    } aluSrcBType;

    typedef enum logic [1:0] {
        pcFromJump   = 2'b00,
        pcFromAlu    = 2'b01,
        pcFromAluOut = 2'b10,
        pcFromEpc    = 2'b11
    } pcSourceType;

    // Memory address select, vectors live at fixed addresses
    typedef enum logic [2:0] {
        addrPc             = 3'b000,
        addrOverflowVector = 3'b010,
        addrIllegalVector  = 3'b011
    } iorDType;

    typedef enum logic [1:0] {
        dstRt     = 2'b01,
        dstReturn = 2'b10,
        dstRd     = 2'b11
    } regDstType;

    typedef enum logic [2:0] {
        dataStackTop = 3'b100,
        dataAluOut   = 3'b110
    } dataSourceType;

endpackage

`default_nettype wire

//--- isaPkg.sv
`default_nettype none

package isaPkg;

    localparam int opcodeWidth = 6;
    localparam int functWidth = 6;

    // Primary opcodes still handled by the control unit
    typedef enum logic [opcodeWidth-1:0] {
        opRType = 6'b000000,
        opJ     = 6'b000010,
        opJal   = 6'b000011,
        opAddi  = 6'b001000,
        opAddiu = 6'b001001
    } opcodeType;

    // Funct field values under the R-type opcode
    typedef enum logic [functWidth-1:0] {
        functJr    = 6'b001000,
        functBreak = 6'b001101,
        functRte   = 6'b010011,
        functAdd   = 6'b100000,
        functSub   = 6'b100010,
        functAnd   = 6'b100100
    } functType;

    // Instruction kind after decode
    // kindIllegal covers every opcode or funct outside the kept set
    typedef enum logic [3:0] {
        kindAdd,
        kindSub,
        kindAnd,
        kindAddi,
        kindAddiu,
        kindJ,
        kindJal,
        kindJr,
        kindBreak,
        kindRte,
        kindIllegal
    } instrKind;

endpackage

`default_nettype wire
